// File: riscv_pipeline.f
+incdir+source
source/riscv_isa_pkg.sv
source/riscv_pipe_pkg.sv
source/instr_decode.sv
source/exec.sv
source/hazard_unit.sv
source/io_regs.sv
source/riscv_pipeline.sv
tests/tb_riscv_pipeline.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_riscv_pipeline
FILELIST  = riscv_pipeline.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_riscv_pipeline.sv
`timescale 1ns/1ps

module tb_riscv_pipeline;

    localparam int NUM_TESTS    = 6;
    localparam int PROG_WORDS   = 16;
    localparam int MEM_WORDS    = 256;
    localparam int RESET_CYCLES = 8;
    localparam int WAIT_CYCLES  = 400;

    localparam int F3_ADD = 0;
    localparam int F3_SLT = 2;
    localparam int F3_XOR = 4;
    localparam int F3_OR  = 6;
    localparam int F3_AND = 7;
    localparam int F3_BEQ = 0;
    localparam int F3_BNE = 1;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] read_data;
    logic [31:0] pc;
    logic        data_we;
    logic [31:0] data_addr;
    logic [31:0] din;
    logic [31:0] status;
    logic [31:0] result_bytes;

    logic [31:0] rom [MEM_WORDS];
    logic [31:0] ram [MEM_WORDS];

    // one row per test
    logic [31:0] prog       [NUM_TESTS][PROG_WORDS];
    string       test_name  [NUM_TESTS];
    logic        init_valid [NUM_TESTS];
    int          init_idx   [NUM_TESTS];
    logic [31:0] init_val   [NUM_TESTS];
    logic [31:0] exp_result [NUM_TESTS];
    logic        check_mem  [NUM_TESTS];
    int          check_idx  [NUM_TESTS];
    logic [31:0] check_val  [NUM_TESTS];

    int          error_count;
    int          pass_count;
    int          cur_test;
    int          cur_len;
    logic [31:0] rng_state;

    riscv_pipeline dut_i (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .pc           (pc),
        .read_data    (read_data),
        .data_we      (data_we),
        .data_addr    (data_addr),
        .din          (din),
        .status       (status),
        .result_bytes (result_bytes)
    );

    always #20 clk = ~clk;

    // memory read ports settle before the next rising edge
    always @(negedge clk) begin
        instr     <= rom[pc[9:2]];
        read_data <= ram[data_addr[9:2]];
    end

    always @(posedge clk) begin
        if (!rst && data_we) begin
            assert (data_addr[31:8] != 24'hFF_FFFF) else begin
                $display("data_we asserted for I/O address 0x%08h", data_addr);
                error_count++;
            end
            ram[data_addr[9:2]] <= din;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] fill_word(int idx);
        return {8'hd1, idx[7:0], ~idx[7:0], idx[7:0]};
    endfunction

    function automatic logic [31:0] arith_rr(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] arith_ri(int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
    endfunction

    function automatic logic [31:0] lui(int rd, int imm20);
        return {imm20[19:0], rd[4:0], 7'h37};
    endfunction

    function automatic logic [31:0] lw(int rd, int rs1, int offset);
        return {offset[11:0], rs1[4:0], 3'b010, rd[4:0], 7'h03};
    endfunction

    function automatic logic [31:0] sw(int rs2, int rs1, int offset);
        return {offset[11:5], rs2[4:0], rs1[4:0], 3'b010, offset[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] branch(int f3, int rs1, int rs2, int offset);
        return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], f3[2:0],
                offset[4:1], offset[11], 7'h63};
    endfunction

    function automatic logic [31:0] jal(int rd, int offset);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic start_test(int t, string name);
        cur_test     = t;
        cur_len      = 0;
        test_name[t] = name;
    endtask

    task automatic emit(logic [31:0] word);
        prog[cur_test][cur_len] = word;
        cur_len++;
    endtask

    // lui then addi with the upper part rounded for the sign of the low 12 bits
    task automatic emit_const(int rd, logic [31:0] value);
        logic [31:0] hi;
        hi = (value + 32'h800) >> 12;
        emit(lui(rd, int'(hi)));
        emit(arith_ri(F3_ADD, rd, rd, int'(value)));
    endtask

    // report rd in result_bytes, set status bit 0, then spin
    task automatic emit_done(int rd);
        emit(arith_ri(F3_ADD, 31, 0, -256));
        emit(sw(rd, 31, 4));
        emit(arith_ri(F3_ADD, 30, 0, 1));
        emit(sw(30, 31, 0));
        emit(jal(0, 0));
    endtask

    task automatic build_tests();
        logic [31:0] a, b, c, d, e, f, g, h;
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int i = 0; i < PROG_WORDS; i++) begin
                prog[t][i] = 32'h0;
            end
            init_valid[t] = 1'b0;
            check_mem[t]  = 1'b0;
        end

        rng_state = xorshift32(rng_state);
        a = rng_state;
        rng_state = xorshift32(rng_state);
        b = rng_state;
        start_test(0, "alu chain");
        emit_const(1, a);
        emit_const(2, b);
        emit(arith_rr(0, F3_ADD, 3, 1, 2));
        emit(arith_rr(32, F3_ADD, 4, 3, 1));
        emit(arith_rr(0, F3_XOR, 5, 4, 3));
        emit(arith_rr(0, F3_OR, 6, 5, 2));
        emit(arith_rr(0, F3_AND, 7, 6, 4));
        emit(arith_rr(0, F3_SLT, 8, 7, 5));
        emit(arith_rr(0, F3_ADD, 9, 7, 8));
        emit_done(9);
        c = a + b;
        d = c - a;
        e = d ^ c;
        f = e | b;
        g = f & d;
        h = ($signed(g) < $signed(e)) ? 32'd1 : 32'd0;
        exp_result[0] = g + h;

        start_test(1, "load use");
        init_valid[1] = 1'b1;
        init_idx[1]   = 4;
        init_val[1]   = 32'h1234_5678;
        emit(lw(1, 0, 16));
        emit(arith_ri(F3_ADD, 2, 1, 32'h123));
        emit_done(2);
        exp_result[1] = 32'h1234_5678 + 32'h123;

        start_test(2, "store reload");
        emit_const(1, 32'h5EED_C0DE);
        emit(sw(1, 0, 32));
        emit(lw(2, 0, 32));
        emit(arith_rr(0, F3_ADD, 3, 2, 0));
        emit_done(3);
        exp_result[2] = 32'h5EED_C0DE;
        check_mem[2]  = 1'b1;
        check_idx[2]  = 8;
        check_val[2]  = 32'h5EED_C0DE;

        start_test(3, "branch jal");
        emit(arith_ri(F3_ADD, 1, 0, 5));
        emit(arith_ri(F3_ADD, 2, 0, 5));
        emit(branch(F3_BEQ, 1, 2, 8));
        emit(arith_ri(F3_ADD, 1, 1, 100));
        emit(branch(F3_BNE, 1, 2, 8));
        emit(arith_ri(F3_ADD, 1, 1, 1));
        emit(jal(5, 8));
        emit(arith_ri(F3_ADD, 1, 1, 1000));
        emit(arith_rr(0, F3_ADD, 3, 1, 5));
        emit_done(3);
        // x1 ends at 5 + 1 and x5 links to the word after the jal at 24
        exp_result[3] = (32'd5 + 32'd1) + (32'd24 + 32'd4);

        start_test(4, "lui x0");
        emit(lui(1, 32'hABCDE));
        emit(arith_ri(F3_OR, 2, 1, 32'h123));
        emit(arith_ri(F3_ADD, 0, 0, 77));
        emit(arith_rr(0, F3_ADD, 3, 2, 0));
        emit(arith_ri(F3_XOR, 4, 3, 32'h0FF));
        emit(arith_ri(F3_AND, 5, 4, -16));
        emit(arith_ri(F3_SLT, 6, 0, 1));
        emit(arith_rr(0, F3_ADD, 7, 5, 6));
        emit_done(7);
        exp_result[4] = (((32'hABCD_E000 | 32'h123) ^ 32'h0FF) & 32'hFFFF_FFF0) + 32'd1;

        start_test(5, "io decode");
        emit_const(1, 32'h600D_1DEA);
        emit_done(1);
        exp_result[5] = 32'h600D_1DEA;
        check_mem[5]  = 1'b1;
        check_idx[5]  = 8'hC1;
        check_val[5]  = fill_word(8'hC1);
    endtask

    task automatic load_memories(int t);
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i] = (i < PROG_WORDS) ? prog[t][i] : 32'h0;
            ram[i] <= fill_word(i);
        end
        if (init_valid[t]) begin
            ram[init_idx[t]] <= init_val[t];
        end
    endtask

    task automatic run_test(int t);
        int  cycles;
        int  errors_before;
        logic done;
        errors_before = error_count;
        @(negedge clk);
        rst = 1'b1;
        load_memories(t);
        repeat (RESET_CYCLES) @(negedge clk);
        rst    = 1'b0;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < WAIT_CYCLES) begin
            @(negedge clk);
            cycles++;
            done = status[0];
        end
        if (!done) begin
            $display("test %0d: status bit 0 was not set within %0d cycles", t, WAIT_CYCLES);
            error_count++;
        end else begin
            assert (result_bytes == exp_result[t]) else begin
                $display("mismatch: test %0d result_bytes got 0x%08h expected 0x%08h",
                         t, result_bytes, exp_result[t]);
                error_count++;
            end
            if (check_mem[t]) begin
                assert (ram[check_idx[t]] == check_val[t]) else begin
                    $display("mismatch: test %0d dmem[0x%02h] got 0x%08h expected 0x%08h",
                             t, check_idx[t], ram[check_idx[t]], check_val[t]);
                    error_count++;
                end
            end
        end
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %0d (%s): ok, %0d cycles", t, test_name[t], cycles);
        end else begin
            $display("test %0d (%s): failed", t, test_name[t]);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        instr       = 32'h0;
        read_data   = 32'h0;
        error_count = 0;
        pass_count  = 0;
        rng_state   = 32'hd679_0f8e;
        build_tests();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 NUM_TESTS, pass_count, NUM_TESTS - pass_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: source/riscv_pipeline.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module riscv_pipeline (
    input  logic                  clk,
    input  logic                  rst,
    input  riscv_pipe_pkg::word_t instr,
    output riscv_pipe_pkg::word_t pc,
    input  riscv_pipe_pkg::word_t read_data,
    output logic                  data_we,
    output riscv_pipe_pkg::word_t data_addr,
    output riscv_pipe_pkg::word_t din,
    output riscv_pipe_pkg::word_t status,
    output riscv_pipe_pkg::word_t result_bytes
);
    import riscv_isa_pkg::*;
    import riscv_pipe_pkg::*;

    word_t       pc_plus4_f, pc_next_f;
    word_t       instr_d, pc_d, pc4_d;
    word_t       rd1_d, rd2_d;
    reg_idx_t    rs1_d, rs2_d, rd_d;
    imm_t        imm_d;
    alu_op_t     alu_op_d;
    logic        alu_src_d, reg_write_d, mem_write_d, branch_d, branch_ne_d, jump_d;
    result_src_t result_src_d;

    logic        reg_write_e, mem_write_e, branch_e, branch_ne_e, jump_e, alu_src_e;
    alu_op_t     alu_op_e;
    result_src_t result_src_e;
    word_t       rd1_e, rd2_e, pc_e, pc4_e;
    reg_idx_t    rs1_e, rs2_e, rd_e;
    imm_t        imm_e;
    word_t       alu_result_e, write_data_e, pc_target_e;
    logic        pc_src_e;

    logic        reg_write_m, mem_write_m;
    result_src_t result_src_m;
    word_t       alu_result_m, write_data_m, pc4_m, read_data_m;
    reg_idx_t    rd_m;

    logic        reg_write_w;
    result_src_t result_src_w;
    word_t       alu_result_w, read_data_w, pc4_w, result_w;
    reg_idx_t    rd_w;

    fwd_sel_t    forward_a_e, forward_b_e;
    logic        stall_f, stall_d, flush_d, flush_e;

    // fetch
    assign pc_plus4_f = pc + 32'd4;
    assign pc_next_f  = pc_src_e ? pc_target_e : pc_plus4_f;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (!stall_f) begin
            pc <= pc_next_f;
        end
    end

    // a zero word in F/D decodes to no control
    always_ff @(posedge clk) begin
        if (rst || flush_d) begin
            instr_d <= '0;
        end else if (!stall_d) begin
            instr_d <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_d) begin
            pc_d  <= pc;
            pc4_d <= pc_plus4_f;
        end
    end

    instr_decode instr_decode_i (
        .clk          (clk),
        .rst          (rst),
        .instr_d      (instr_d),
        .reg_write_w  (reg_write_w),
        .rd_w         (rd_w),
        .result_w     (result_w),
        .rd1_d        (rd1_d),
        .rd2_d        (rd2_d),
        .rs1_d        (rs1_d),
        .rs2_d        (rs2_d),
        .rd_d         (rd_d),
        .imm_d        (imm_d),
        .alu_op_d     (alu_op_d),
        .alu_src_d    (alu_src_d),
        .reg_write_d  (reg_write_d),
        .mem_write_d  (mem_write_d),
        .branch_d     (branch_d),
        .branch_ne_d  (branch_ne_d),
        .jump_d       (jump_d),
        .result_src_d (result_src_d)
    );

    // a flush of D/E leaves a bubble
    always_ff @(posedge clk) begin
        if (rst || flush_e) begin
            reg_write_e  <= 1'b0;
            mem_write_e  <= 1'b0;
            branch_e     <= 1'b0;
            branch_ne_e  <= 1'b0;
            jump_e       <= 1'b0;
            alu_src_e    <= 1'b0;
            alu_op_e     <= ALU_ADD;
            result_src_e <= RES_ALU;
        end else begin
            reg_write_e  <= reg_write_d;
            mem_write_e  <= mem_write_d;
            branch_e     <= branch_d;
            branch_ne_e  <= branch_ne_d;
            jump_e       <= jump_d;
            alu_src_e    <= alu_src_d;
            alu_op_e     <= alu_op_d;
            result_src_e <= result_src_d;
        end
    end

    always_ff @(posedge clk) begin
        rd1_e <= rd1_d;
        rd2_e <= rd2_d;
        pc_e  <= pc_d;
        pc4_e <= pc4_d;
        rs1_e <= rs1_d;
        rs2_e <= rs2_d;
        rd_e  <= rd_d;
        imm_e <= imm_d;
    end

    exec exec_i (
        .rd1_e        (rd1_e),
        .rd2_e        (rd2_e),
        .pc_e         (pc_e),
        .imm_e        (imm_e),
        .alu_op_e     (alu_op_e),
        .alu_src_e    (alu_src_e),
        .branch_e     (branch_e),
        .branch_ne_e  (branch_ne_e),
        .jump_e       (jump_e),
        .forward_a_e  (forward_a_e),
        .forward_b_e  (forward_b_e),
        .alu_result_m (alu_result_m),
        .result_w     (result_w),
        .alu_result_e (alu_result_e),
        .write_data_e (write_data_e),
        .pc_target_e  (pc_target_e),
        .pc_src_e     (pc_src_e)
    );

    // E/M
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_write_m <= 1'b0;
            mem_write_m <= 1'b0;
        end else begin
            reg_write_m <= reg_write_e;
            mem_write_m <= mem_write_e;
        end
    end

    always_ff @(posedge clk) begin
        result_src_m <= result_src_e;
        alu_result_m <= alu_result_e;
        write_data_m <= write_data_e;
        rd_m         <= rd_e;
        pc4_m        <= pc4_e;
    end

    io_regs io_regs_i (
        .clk          (clk),
        .rst          (rst),
        .mem_write_m  (mem_write_m),
        .alu_result_m (alu_result_m),
        .write_data_m (write_data_m),
        .read_data    (read_data),
        .data_we      (data_we),
        .data_addr    (data_addr),
        .din          (din),
        .read_data_m  (read_data_m),
        .status       (status),
        .result_bytes (result_bytes)
    );

    // M/W
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_write_w <= 1'b0;
        end else begin
            reg_write_w <= reg_write_m;
        end
    end

    always_ff @(posedge clk) begin
        result_src_w <= result_src_m;
        alu_result_w <= alu_result_m;
        read_data_w  <= read_data_m;
        rd_w         <= rd_m;
        pc4_w        <= pc4_m;
    end

    always_comb begin
        case (result_src_w)
            RES_MEM: result_w = read_data_w;
            RES_PC4: result_w = pc4_w;
            default: result_w = alu_result_w;
        endcase
    end

    hazard_unit hazard_unit_i (
        .rs1_d        (rs1_d),
        .rs2_d        (rs2_d),
        .rs1_e        (rs1_e),
        .rs2_e        (rs2_e),
        .rd_e         (rd_e),
        .rd_m         (rd_m),
        .rd_w         (rd_w),
        .result_src_e (result_src_e),
        .reg_write_m  (reg_write_m),
        .reg_write_w  (reg_write_w),
        .pc_src_e     (pc_src_e),
        .forward_a_e  (forward_a_e),
        .forward_b_e  (forward_b_e),
        .stall_f      (stall_f),
        .stall_d      (stall_d),
        .flush_d      (flush_d),
        .flush_e      (flush_e)
    );

endmodule

// File: source/io_regs.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module io_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_write_m,
    input  riscv_pipe_pkg::word_t alu_result_m,
    input  riscv_pipe_pkg::word_t write_data_m,
    input  riscv_pipe_pkg::word_t read_data,
    output logic                  data_we,
    output riscv_pipe_pkg::word_t data_addr,
    output riscv_pipe_pkg::word_t din,
    output riscv_pipe_pkg::word_t read_data_m,
    output riscv_pipe_pkg::word_t status,
    output riscv_pipe_pkg::word_t result_bytes
);
    logic is_io;
    logic hit_status;
    logic hit_result;

    // top 24 bits select the I/O page
    assign is_io      = (alu_result_m[31:8] == `IO_BASE >> 8);
    assign hit_status = (alu_result_m == `IO_STATUS_ADDR);
    assign hit_result = (alu_result_m == `IO_RESULT_ADDR);

    assign data_we   = mem_write_m & ~is_io;
    assign data_addr = alu_result_m;
    assign din       = write_data_m;

    always_ff @(posedge clk) begin
        if (rst) begin
            status       <= '0;
            result_bytes <= '0;
        end else if (mem_write_m) begin
            if (hit_status) begin
                status <= write_data_m;
            end
            if (hit_result) begin
                result_bytes <= write_data_m;
            end
        end
    end

    always_comb begin
        if (!is_io) begin
            read_data_m = read_data;
        end else if (hit_status) begin
            read_data_m = status;
        end else if (hit_result) begin
            read_data_m = result_bytes;
        end else begin
            read_data_m = '0;
        end
    end

endmodule

// File: source/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  riscv_pipe_pkg::reg_idx_t    rs1_d,
    input  riscv_pipe_pkg::reg_idx_t    rs2_d,
    input  riscv_pipe_pkg::reg_idx_t    rs1_e,
    input  riscv_pipe_pkg::reg_idx_t    rs2_e,
    input  riscv_pipe_pkg::reg_idx_t    rd_e,
    input  riscv_pipe_pkg::reg_idx_t    rd_m,
    input  riscv_pipe_pkg::reg_idx_t    rd_w,
    input  riscv_pipe_pkg::result_src_t result_src_e,
    input  logic                        reg_write_m,
    input  logic                        reg_write_w,
    input  logic                        pc_src_e,
    output riscv_pipe_pkg::fwd_sel_t    forward_a_e,
    output riscv_pipe_pkg::fwd_sel_t    forward_b_e,
    output logic                        stall_f,
    output logic                        stall_d,
    output logic                        flush_d,
    output logic                        flush_e
);
    import riscv_pipe_pkg::*;

    logic load_use;

    // newer result in memory wins over write-back
    function automatic fwd_sel_t fwd_select(reg_idx_t rs);
        if (rs == '0) begin
            return FWD_NONE;
        end else if (reg_write_m && rd_m == rs) begin
            return FWD_MEM;
        end else if (reg_write_w && rd_w == rs) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign forward_a_e = fwd_select(rs1_e);
    assign forward_b_e = fwd_select(rs2_e);

    assign load_use = (result_src_e == RES_MEM) && (rd_e != '0) &&
                      (rd_e == rs1_d || rd_e == rs2_d);

    assign stall_f = load_use;
    assign stall_d = load_use;
    assign flush_d = pc_src_e;
    assign flush_e = load_use | pc_src_e;

endmodule

// File: source/exec.sv
`timescale 1ns/1ps

module exec (
    input  riscv_pipe_pkg::word_t    rd1_e,
    input  riscv_pipe_pkg::word_t    rd2_e,
    input  riscv_pipe_pkg::word_t    pc_e,
    input  riscv_pipe_pkg::imm_t     imm_e,
    input  riscv_isa_pkg::alu_op_t   alu_op_e,
    input  logic                     alu_src_e,
    input  logic                     branch_e,
    input  logic                     branch_ne_e,
    input  logic                     jump_e,
    input  riscv_pipe_pkg::fwd_sel_t forward_a_e,
    input  riscv_pipe_pkg::fwd_sel_t forward_b_e,
    input  riscv_pipe_pkg::word_t    alu_result_m,
    input  riscv_pipe_pkg::word_t    result_w,
    output riscv_pipe_pkg::word_t    alu_result_e,
    output riscv_pipe_pkg::word_t    write_data_e,
    output riscv_pipe_pkg::word_t    pc_target_e,
    output logic                     pc_src_e
);
    import riscv_isa_pkg::*;
    import riscv_pipe_pkg::*;

    word_t src_a;
    word_t src_b;
    logic  equal;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a        = fwd_mux(forward_a_e, rd1_e, alu_result_m, result_w);
    assign write_data_e = fwd_mux(forward_b_e, rd2_e, alu_result_m, result_w);
    assign src_b        = alu_src_e ? imm_e : write_data_e;

    always_comb begin
        case (alu_op_e)
            ALU_ADD:    alu_result_e = src_a + src_b;
            ALU_SUB:    alu_result_e = src_a - src_b;
            ALU_AND:    alu_result_e = src_a & src_b;
            ALU_OR:     alu_result_e = src_a | src_b;
            ALU_XOR:    alu_result_e = src_a ^ src_b;
            ALU_SLT:    alu_result_e = word_t'($signed(src_a) < $signed(src_b));
            ALU_PASS_B: alu_result_e = src_b;
            default:    alu_result_e = src_b;
        endcase
    end

    // beq/bne compare the register operands, never the immediate
    assign equal       = (src_a == write_data_e);
    assign pc_src_e    = jump_e | (branch_e & (equal ^ branch_ne_e));
    assign pc_target_e = pc_e + imm_e;

endmodule

// File: source/instr_decode.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module instr_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  riscv_pipe_pkg::word_t       instr_d,
    input  logic                        reg_write_w,
    input  riscv_pipe_pkg::reg_idx_t    rd_w,
    input  riscv_pipe_pkg::word_t       result_w,
    output riscv_pipe_pkg::word_t       rd1_d,
    output riscv_pipe_pkg::word_t       rd2_d,
    output riscv_pipe_pkg::reg_idx_t    rs1_d,
    output riscv_pipe_pkg::reg_idx_t    rs2_d,
    output riscv_pipe_pkg::reg_idx_t    rd_d,
    output riscv_pipe_pkg::imm_t        imm_d,
    output riscv_isa_pkg::alu_op_t      alu_op_d,
    output logic                        alu_src_d,
    output logic                        reg_write_d,
    output logic                        mem_write_d,
    output logic                        branch_d,
    output logic                        branch_ne_d,
    output logic                        jump_d,
    output riscv_pipe_pkg::result_src_t result_src_d
);
    import riscv_isa_pkg::*;
    import riscv_pipe_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    word_t   regs [1:`REG_COUNT-1];
    logic    write_en;

    assign opcode = instr_d[6:0];
    assign funct3 = instr_d[14:12];
    assign rs1_d  = instr_d[19:15];
    assign rs2_d  = instr_d[24:20];
    assign rd_d   = instr_d[11:7];

    function automatic alu_op_t alu_from_funct3(funct3_t f3, logic sub);
        case (f3)
            F3_ADD_SUB: return sub ? ALU_SUB : ALU_ADD;
            F3_SLT:     return ALU_SLT;
            F3_XOR:     return ALU_XOR;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    always_comb begin
        alu_op_d     = ALU_ADD;
        alu_src_d    = 1'b0;
        reg_write_d  = 1'b0;
        mem_write_d  = 1'b0;
        branch_d     = 1'b0;
        branch_ne_d  = 1'b0;
        jump_d       = 1'b0;
        result_src_d = RES_ALU;
        imm_d        = {{20{instr_d[31]}}, instr_d[31:20]};
        case (opcode)
            OPC_OP: begin
                reg_write_d = 1'b1;
                alu_op_d    = alu_from_funct3(funct3, instr_d[30]);
            end
            OPC_OP_IMM: begin
                reg_write_d = 1'b1;
                alu_src_d   = 1'b1;
                alu_op_d    = alu_from_funct3(funct3, 1'b0);
            end
            OPC_LUI: begin
                reg_write_d = 1'b1;
                alu_src_d   = 1'b1;
                alu_op_d    = ALU_PASS_B;
                imm_d       = {instr_d[31:12], 12'b0};
            end
            OPC_LOAD: begin
                reg_write_d  = 1'b1;
                alu_src_d    = 1'b1;
                result_src_d = RES_MEM;
            end
            OPC_STORE: begin
                mem_write_d = 1'b1;
                alu_src_d   = 1'b1;
                imm_d       = {{20{instr_d[31]}}, instr_d[31:25], instr_d[11:7]};
            end
            OPC_BRANCH: begin
                branch_d    = 1'b1;
                branch_ne_d = (funct3 == F3_BNE);
                imm_d       = {{19{instr_d[31]}}, instr_d[31], instr_d[7],
                               instr_d[30:25], instr_d[11:8], 1'b0};
            end
            OPC_JAL: begin
                jump_d       = 1'b1;
                reg_write_d  = 1'b1;
                result_src_d = RES_PC4;
                imm_d        = {{11{instr_d[31]}}, instr_d[31], instr_d[19:12],
                                instr_d[20], instr_d[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    // x0 is never stored
    assign write_en = reg_write_w && !rst && (rd_w != '0);

    always_ff @(posedge clk) begin
        if (write_en) begin
            regs[rd_w] <= result_w;
        end
    end

    // same-cycle write shows up on the read ports
    assign rd1_d = (rs1_d == '0) ? '0 :
                   (write_en && rd_w == rs1_d) ? result_w : regs[rs1_d];
    assign rd2_d = (rs2_d == '0) ? '0 :
                   (write_en && rd_w == rs2_d) ? result_w : regs[rs2_d];

endmodule

// File: source/riscv_pipe_pkg.sv
`include "riscv_defines.svh"

package riscv_pipe_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    // sign-extended immediate as wide as a word
    typedef logic [`XLEN-1:0] imm_t;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_WB   = 2'd1,
        FWD_MEM  = 2'd2
    } fwd_sel_t;

endpackage

// File: source/riscv_isa_pkg.sv
package riscv_isa_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // major opcodes of the supported subset
    localparam opcode_t OPC_OP     = 7'b011_0011;
    localparam opcode_t OPC_OP_IMM = 7'b001_0011;
    localparam opcode_t OPC_LUI    = 7'b011_0111;
    localparam opcode_t OPC_LOAD   = 7'b000_0011;
    localparam opcode_t OPC_STORE  = 7'b010_0011;
    localparam opcode_t OPC_BRANCH = 7'b110_0011;
    localparam opcode_t OPC_JAL    = 7'b110_1111;

    // funct3 for the ALU group
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // branch compare
    localparam funct3_t F3_BNE = 3'b001;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_t;

endpackage

// File: source/riscv_defines.svh
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

`define XLEN 32
`define REG_COUNT 32

`define RESET_PC 32'h0000_0000

// memory-mapped I/O window
`define IO_BASE 32'hFFFF_FF00
`define IO_STATUS_ADDR (`IO_BASE + 32'h0000_0000)
`define IO_RESULT_ADDR (`IO_BASE + 32'h0000_0004)

`endif
